// File: Makefile
# Verilator build and run of the TCDM subsystem testbench.

VERILATOR ?= verilator
TOP       ?= tcdm_subsystem_tb
FILELIST  ?= tcdm_subsystem.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= Simulation completed successfully

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// File: bench/tcdm_subsystem_tb.sv
/*
 * Testbench for the TCDM subsystem.
 * Clock, reset, LCG stimulus, reference memory model and assertions.
 */

`timescale 1ns/1ps
`default_nettype none

`include "tcdm_config.svh"

module tcdm_subsystem_tb import tcdm_pkg::*; ();

    localparam int NumIn   = `TCDM_NUM_IN;
    localparam int WaitMax = 16;

    logic                                          clk_i;
    logic                                          reset_i;
    mem_req_t [`TCDM_NUM_IN-1:0]                   req;
    mem_rsp_t [`TCDM_NUM_IN-1:0]                   rsp;
    logic     [`TCDM_NUM_IN-1:0]                   valid_vec;
    logic     [`TCDM_NUM_IN-1:0]                   acc_vec;
    logic     [`TCDM_NUM_IN-1:0]                   exp_valid;
    logic     [`TCDM_NUM_IN-1:0]                   exp_read;
    logic     [`TCDM_NUM_IN-1:0][`TCDM_DATA_WIDTH-1:0] exp_rdata;
    logic     [`TCDM_NUM_IN-1:0]                   served;
    int                                            wait_cnt [`TCDM_NUM_IN];
    logic     [`TCDM_DATA_WIDTH-1:0]               model_mem [64];
    logic     [31:0]                               lcg_state;
    logic                                          fair_phase;
    string                                         test_name;
    int                                            check_errors;
    int                                            timeout_errors;

    tcdm_subsystem tcdm_subsystem_inst (
        .clk_i     (clk_i),
        .reset_i   (reset_i),
        .mem_req_i (req),
        .mem_rsp_o (rsp)
    );

    always #50 clk_i = ~clk_i;

    // ************************************************************
    // helpers
    // ************************************************************

    function automatic logic [31:0] next_rand();
        logic [15:0] hi;
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        hi        = lcg_state[31:16];  // low bits have short periods.
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return {hi, lcg_state[31:16]};
    endfunction

    // byte bits, then 2 bank bits, then 4 row bits.
    function automatic int bank_of(input logic [`TCDM_ADDR_WIDTH-1:0] addr);
        return int'(addr[3:2]);
    endfunction

    function automatic int word_of(input logic [`TCDM_ADDR_WIDTH-1:0] addr);
        return int'(addr[7:2]);
    endfunction

    function automatic logic [31:0] fill_word(input logic [31:0] addr);
        return (addr * 32'h9e37_79b1) ^ 32'h5a5a_0f0f;
    endfunction

    function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                                input logic [31:0] wdata,
                                                input logic [3:0]  strb);
        logic [31:0] res;
        res = old_word;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                res[b*8 +: 8] = wdata[b*8 +: 8];
            end
        end
        return res;
    endfunction

    // ports in mask whose address decodes to bank.
    function automatic int port_count(input logic [`TCDM_NUM_IN-1:0] mask, input int bank);
        int n;
        n = 0;
        for (int i = 0; i < NumIn; i++) begin
            if (mask[i] && bank_of(req[i].q.addr) == bank) begin
                n++;
            end
        end
        return n;
    endfunction

    always_comb begin
        for (int i = 0; i < NumIn; i++) begin
            valid_vec[i] = req[i].q_valid;
            acc_vec[i]   = req[i].q_valid && rsp[i].q_ready;
        end
    end

    // ************************************************************
    // reference model and response tracking
    // ************************************************************

    always @(posedge clk_i) begin
        if (reset_i) begin
            exp_valid <= '0;
            exp_read  <= '0;
            served    <= '0;
            for (int i = 0; i < NumIn; i++) begin
                wait_cnt[i] <= 0;
            end
        end else begin
            for (int i = 0; i < NumIn; i++) begin
                if (acc_vec[i] && req[i].q.op == TCDM_READ) begin
                    exp_rdata[i] <= model_mem[word_of(req[i].q.addr)];  // pre-write value.
                end
                exp_read[i] <= (req[i].q.op == TCDM_READ);
                wait_cnt[i] <= (req[i].q_valid && !acc_vec[i]) ? wait_cnt[i] + 1 : 0;
            end
            for (int i = 0; i < NumIn; i++) begin
                if (acc_vec[i] && req[i].q.op == TCDM_WRITE) begin
                    model_mem[word_of(req[i].q.addr)] = merge_bytes(
                        model_mem[word_of(req[i].q.addr)], req[i].q.wdata, req[i].q.strb);
                end
            end
            exp_valid <= acc_vec;
            if (!fair_phase || &(served | acc_vec)) begin
                served <= '0;  // new round.
            end else begin
                served <= served | acc_vec;
            end
        end
    end

    // ************************************************************
    // assertions at the falling edge
    // ************************************************************

    for (genvar i = 0; i < `TCDM_NUM_IN; i++) begin : gen_port_checks
        assert property (@(negedge clk_i) rsp[i].p.valid === exp_valid[i])
            else begin
                check_errors++;
                $display("CHECK FAILED %s p.valid port %0d: expected %b actual %b",
                         test_name, i, exp_valid[i], rsp[i].p.valid);
            end
        assert property (@(negedge clk_i)
                         !(exp_valid[i] && exp_read[i]) || rsp[i].p.rdata === exp_rdata[i])
            else begin
                check_errors++;
                $display("CHECK FAILED %s rdata port %0d: expected %h actual %h",
                         test_name, i, exp_rdata[i], rsp[i].p.rdata);
            end
        assert property (@(negedge clk_i) !req[i].q_valid || wait_cnt[i] < NumIn)
            else begin
                check_errors++;
                $display("%s: port %0d has waited %0d cycles for q_ready",
                         test_name, i, wait_cnt[i] + 1);
            end
        assert property (@(negedge clk_i) !(fair_phase && acc_vec[i] && served[i]))
            else begin
                check_errors++;
                $display("%s: port %0d was accepted twice before every port was served",
                         test_name, i);
            end
    end

    // exactly one acceptance per bank that has a requester.
    for (genvar j = 0; j < `TCDM_NUM_OUT; j++) begin : gen_bank_checks
        assert property (@(negedge clk_i)
                         port_count(acc_vec, j) == ((port_count(valid_vec, j) > 0) ? 1 : 0))
            else begin
                check_errors++;
                $display("CHECK FAILED %s accepts on bank %0d: expected %0d actual %0d",
                         test_name, j, (port_count(valid_vec, j) > 0) ? 1 : 0,
                         port_count(acc_vec, j));
            end
    end

    // ************************************************************
    // stimulus
    // ************************************************************

    task automatic issue(input int p, input tcdm_op_e op,
                         input logic [`TCDM_ADDR_WIDTH-1:0] addr,
                         input logic [`TCDM_DATA_WIDTH-1:0] wdata, input logic [3:0] strb);
        mem_req_t nreq;
        logic     done;
        int       waited;
        nreq    = '{q_valid: 1'b1, q: '{op: op, addr: addr, wdata: wdata, strb: strb}};
        req[p]  = nreq;
        done    = 1'b0;
        waited  = 0;
        while (!done && waited < WaitMax) begin
            @(negedge clk_i);
            done = acc_vec[p];
            @(posedge clk_i);
            #1;
            waited++;
        end
        if (!done) begin
            timeout_errors++;
            $display("port %0d: request to %h was not accepted within %0d cycles",
                     p, addr, WaitMax);
        end
        req[p].q_valid = 1'b0;
    endtask

    task automatic fill_port(input int p);
        logic [31:0] addr;
        for (int k = 0; k < 16; k++) begin
            addr = 32'((4 * k + p) * 4);  // every word of bank p.
            issue(p, TCDM_WRITE, addr, fill_word(addr), 4'hf);
        end
    endtask

    task automatic strobe_test();
        logic [3:0] strbs [4];
        strbs = '{4'b0001, 4'b0110, 4'b1000, 4'b1011};
        for (int k = 0; k < 4; k++) begin
            issue(0, TCDM_WRITE, 32'((k + 5) * 4), next_rand(), strbs[k]);
        end
        issue(0, TCDM_WRITE, 32'h8000_0014, next_rand(), 4'b0100);  // alias of word 5.
        for (int k = 0; k < 4; k++) begin
            issue(0, TCDM_READ, 32'((k + 5) * 4), '0, '0);
        end
    endtask

    // all ports on bank 2.
    task automatic hammer_bank(input int p);
        logic [31:0] addr;
        for (int k = 0; k < 3; k++) begin
            addr = 32'((((p * 3 + k) % 16) * 4 + 2) * 4);
            issue(p, (k == 1) ? TCDM_READ : TCDM_WRITE, addr, ~fill_word(addr), 4'hf);
        end
    endtask

    task automatic random_traffic(input int cycles);
        logic [`TCDM_NUM_IN-1:0] taken;
        logic [31:0]             r;
        for (int c = 0; c < cycles; c++) begin
            @(negedge clk_i);
            taken = acc_vec;
            @(posedge clk_i);
            #1;
            for (int p = 0; p < NumIn; p++) begin
                if (taken[p] || !req[p].q_valid) begin
                    r                = next_rand();
                    req[p].q_valid   = (r[31:28] < 4'd12);
                    req[p].q.op      = r[27] ? TCDM_WRITE : TCDM_READ;
                    req[p].q.strb    = r[26:23];
                    req[p].q.addr    = next_rand();
                    req[p].q.wdata   = next_rand();
                end
            end
        end
    endtask

    task automatic drain_ports();
        logic [`TCDM_NUM_IN-1:0] taken;
        int                      waited;
        waited = 0;
        while (|valid_vec && waited < WaitMax) begin
            @(negedge clk_i);
            taken = acc_vec;
            @(posedge clk_i);
            #1;
            for (int p = 0; p < NumIn; p++) begin
                if (taken[p]) begin
                    req[p].q_valid = 1'b0;
                end
            end
            waited++;
        end
        if (|valid_vec) begin
            timeout_errors++;
            $display("requests still pending after %0d drain cycles", WaitMax);
        end
    endtask

    initial begin
        clk_i          = 1'b0;
        reset_i        = 1'b1;
        req            = '0;
        fair_phase     = 1'b0;
        lcg_state      = 32'd38070;
        check_errors   = 0;
        timeout_errors = 0;
        test_name      = "reset";
        repeat (2) @(posedge clk_i);
        #1;
        reset_i   = 1'b0;
        test_name = "idle";
        repeat (3) @(posedge clk_i);
        #1;
        test_name = "fill";  // each port writes its own bank every cycle.
        fork
            fill_port(0);
            fill_port(1);
            fill_port(2);
            fill_port(3);
        join
        test_name = "strobes";
        strobe_test();
        test_name  = "fairness";
        fair_phase = 1'b1;
        fork
            hammer_bank(0);
            hammer_bank(1);
            hammer_bank(2);
            hammer_bank(3);
        join
        fair_phase = 1'b0;
        test_name  = "random";
        random_traffic(400);
        drain_ports();
        test_name = "final idle";
        repeat (4) @(posedge clk_i);
        $display("errors: checks=%0d timeouts=%0d", check_errors, timeout_errors);
        if (check_errors == 0 && timeout_errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        #200_000;  // 2000 cycles.
        $display("simulation time limit reached");
        $display("Simulation failed");
        $finish;
    end

endmodule : tcdm_subsystem_tb

`default_nettype wire

// File: hw/tcdm_bank.sv
/*
 * Single-port SRAM bank.
 * Byte-enabled write, registered read data.
 */

`timescale 1ns/1ps
`default_nettype none

`include "tcdm_config.svh"

module tcdm_bank import tcdm_pkg::*; (
    input  logic                        clk_i,
    input  bank_req_t                   bank_req_i,
    output logic [`TCDM_DATA_WIDTH-1:0] rdata_o
);

    localparam int unsigned Depth    = 2 ** `TCDM_BANK_ADDR_WIDTH;
    localparam int unsigned NumBytes = `TCDM_DATA_WIDTH / 8;

    logic [`TCDM_DATA_WIDTH-1:0] mem_q [Depth];
    logic [`TCDM_DATA_WIDTH-1:0] rdata_q;

    always_ff @(posedge clk_i) begin
        if (bank_req_i.en) begin
            if (bank_req_i.we) begin
                for (int unsigned b = 0; b < NumBytes; b++) begin
                    if (bank_req_i.strb[b]) begin
                        mem_q[bank_req_i.addr][b*8 +: 8] <= bank_req_i.wdata[b*8 +: 8];
                    end
                end
            end else begin
                rdata_q <= mem_q[bank_req_i.addr];  // valid next cycle.
            end
        end
    end

    assign rdata_o = rdata_q;

endmodule : tcdm_bank

`default_nettype wire

// File: hw/tcdm_config.svh
/*
 * Build-time sizes of the TCDM subsystem.
 * Port count, bank count, word and address widths, bank depth.
 */

`ifndef TCDM_CONFIG_SVH
`define TCDM_CONFIG_SVH

// requester ports competing for the banks.
`define TCDM_NUM_IN 4

// word-interleaved banks, power of two.
`define TCDM_NUM_OUT 4

// byte address width seen by the requesters.
`define TCDM_ADDR_WIDTH 32

// data word width, a multiple of 8.
`define TCDM_DATA_WIDTH 32

// row bits per bank.
`define TCDM_BANK_ADDR_WIDTH 4 // 16 words per bank.

`endif

// File: hw/tcdm_interconnect_wrap.sv
/*
 * Struct-ported TCDM crossbar.
 * Address decode, one round-robin arbiter per bank, bank request mux,
 * and one-cycle response routing back to the requesters.
 */

`timescale 1ns/1ps
`default_nettype none

`include "tcdm_config.svh"

module tcdm_interconnect_wrap import tcdm_pkg::*; (
    input  logic                                            clk_i,
    input  logic                                            reset_i,

    input  mem_req_t  [`TCDM_NUM_IN-1:0]                    mem_req_i,
    output mem_rsp_t  [`TCDM_NUM_IN-1:0]                    mem_rsp_o,

    output bank_req_t [`TCDM_NUM_OUT-1:0]                   bank_req_o,
    input  logic      [`TCDM_NUM_OUT-1:0][`TCDM_DATA_WIDTH-1:0] bank_rdata_i
);

    localparam int unsigned ByteOffWidth = $clog2(`TCDM_DATA_WIDTH / 8);
    localparam int unsigned BankSelWidth = $clog2(`TCDM_NUM_OUT);
    localparam int unsigned RowLsb       = ByteOffWidth + BankSelWidth;

    logic [`TCDM_NUM_IN-1:0][BankSelWidth-1:0]          port_bank;
    logic [`TCDM_NUM_IN-1:0][`TCDM_BANK_ADDR_WIDTH-1:0] port_row;
    logic [`TCDM_NUM_IN-1:0]                            port_gnt;

    logic [`TCDM_NUM_OUT-1:0][`TCDM_NUM_IN-1:0] bank_req_vec;
    logic [`TCDM_NUM_OUT-1:0][`TCDM_NUM_IN-1:0] bank_gnt;

    logic [`TCDM_NUM_IN-1:0]                   rsp_valid_q;
    logic [`TCDM_NUM_IN-1:0][BankSelWidth-1:0] rsp_bank_q;

    // ************************************************************
    // address decode
    // ************************************************************

    for (genvar i = 0; i < `TCDM_NUM_IN; i++) begin : gen_decode
        assign port_bank[i] = mem_req_i[i].q.addr[ByteOffWidth +: BankSelWidth];
        assign port_row[i]  = mem_req_i[i].q.addr[RowLsb +: `TCDM_BANK_ADDR_WIDTH];
    end

    // one request bit per port and bank.
    always_comb begin
        for (int unsigned j = 0; j < `TCDM_NUM_OUT; j++) begin
            for (int unsigned i = 0; i < `TCDM_NUM_IN; i++) begin
                bank_req_vec[j][i] = mem_req_i[i].q_valid &&
                                     (port_bank[i] == BankSelWidth'(j));
            end
        end
    end

    // ************************************************************
    // per-bank arbitration and request mux
    // ************************************************************

    for (genvar j = 0; j < `TCDM_NUM_OUT; j++) begin : gen_bank
        bank_req_t bank_mux;

        tcdm_rr_arbiter #(
            .NumReq(`TCDM_NUM_IN)
        ) i_arbiter (
            .clk_i   (clk_i),
            .reset_i (reset_i),
            .req_i   (bank_req_vec[j]),
            .gnt_o   (bank_gnt[j])
        );

        // grant is one-hot, so at most one port lands here.
        always_comb begin
            bank_mux    = '0;
            bank_mux.en = |bank_gnt[j];
            for (int unsigned i = 0; i < `TCDM_NUM_IN; i++) begin
                if (bank_gnt[j][i]) begin
                    bank_mux.we    = (mem_req_i[i].q.op == TCDM_WRITE);
                    bank_mux.addr  = port_row[i];
                    bank_mux.wdata = mem_req_i[i].q.wdata;
                    bank_mux.strb  = mem_req_i[i].q.strb;
                end
            end
        end

        assign bank_req_o[j] = bank_mux;
    end

    // a port is ready when any bank granted it.
    always_comb begin
        port_gnt = '0;
        for (int unsigned j = 0; j < `TCDM_NUM_OUT; j++) begin
            port_gnt = port_gnt | bank_gnt[j];
        end
    end

    // ************************************************************
    // response routing
    // ************************************************************

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            rsp_valid_q <= '0;
        end else begin
            rsp_valid_q <= port_gnt;
        end
    end

    always_ff @(posedge clk_i) begin
        rsp_bank_q <= port_bank;  // bank that serves each port.
    end

    for (genvar i = 0; i < `TCDM_NUM_IN; i++) begin : gen_rsp
        assign mem_rsp_o[i] = '{
            q_ready: port_gnt[i],
            p:       '{valid: rsp_valid_q[i], rdata: bank_rdata_i[rsp_bank_q[i]]}
        };
    end

endmodule : tcdm_interconnect_wrap

`default_nettype wire

// File: hw/tcdm_pkg.sv
/*
 * Shared types of the TCDM subsystem.
 * Opcode enum, requester request and response structs, bank request struct.
 */

`default_nettype none

`include "tcdm_config.svh"

package tcdm_pkg;

    typedef enum logic {
        TCDM_READ  = 1'b0,
        TCDM_WRITE = 1'b1
    } tcdm_op_e;

    // request channel of one requester.
    typedef struct packed {
        tcdm_op_e                        op;
        logic [`TCDM_ADDR_WIDTH-1:0]     addr;  // byte address.
        logic [`TCDM_DATA_WIDTH-1:0]     wdata;
        logic [`TCDM_DATA_WIDTH/8-1:0]   strb;  // one bit per byte.
    } tcdm_req_chan_t;

    typedef struct packed {
        logic           q_valid;
        tcdm_req_chan_t q;
    } mem_req_t;

    // response channel, one cycle after acceptance.
    typedef struct packed {
        logic                        valid;
        logic [`TCDM_DATA_WIDTH-1:0] rdata;
    } tcdm_rsp_chan_t;

    typedef struct packed {
        logic           q_ready;
        tcdm_rsp_chan_t p;
    } mem_rsp_t;

    // what the crossbar drives into one bank.
    typedef struct packed {
        logic                             en;
        logic                             we;
        logic [`TCDM_BANK_ADDR_WIDTH-1:0] addr;  // row.
        logic [`TCDM_DATA_WIDTH-1:0]      wdata;
        logic [`TCDM_DATA_WIDTH/8-1:0]    strb;
    } bank_req_t;

endpackage : tcdm_pkg

`default_nettype wire

// File: hw/tcdm_rr_arbiter.sv
/*
 * Round-robin arbiter for one bank.
 * Combinational one-hot grant, pointer moves past the winner.
 */

`timescale 1ns/1ps
`default_nettype none

module tcdm_rr_arbiter #(
    parameter int unsigned NumReq = 4
)(
    input  logic              clk_i,
    input  logic              reset_i,
    input  logic [NumReq-1:0] req_i,
    output logic [NumReq-1:0] gnt_o
);

    localparam int unsigned PtrWidth = (NumReq > 1) ? $clog2(NumReq) : 1;

    logic [PtrWidth-1:0] ptr_q;
    logic [PtrWidth-1:0] win_idx;
    logic                found;

    // first requester at or after the pointer, wrapping.
    always_comb begin
        int unsigned idx;
        gnt_o   = '0;
        win_idx = ptr_q;
        found   = 1'b0;
        for (int unsigned k = 0; k < NumReq; k++) begin
            idx = (int'(ptr_q) + k) % NumReq;
            if (!found && req_i[idx]) begin
                found      = 1'b1;
                gnt_o[idx] = 1'b1;
                win_idx    = PtrWidth'(idx);
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            ptr_q <= '0;
        end else if (found) begin
            ptr_q <= (win_idx == PtrWidth'(NumReq - 1)) ? '0 : win_idx + 1'b1;
        end
    end

endmodule : tcdm_rr_arbiter

`default_nettype wire

// File: hw/tcdm_subsystem.sv
/*
 * TCDM subsystem top level.
 * Crossbar plus one SRAM bank per output.
 */

`timescale 1ns/1ps
`default_nettype none

`include "tcdm_config.svh"

module tcdm_subsystem import tcdm_pkg::*; (
    input  logic                          clk_i,
    input  logic                          reset_i,
    input  mem_req_t [`TCDM_NUM_IN-1:0]   mem_req_i,
    output mem_rsp_t [`TCDM_NUM_IN-1:0]   mem_rsp_o
);

    bank_req_t [`TCDM_NUM_OUT-1:0]                        bank_req;
    logic      [`TCDM_NUM_OUT-1:0][`TCDM_DATA_WIDTH-1:0] bank_rdata;

    tcdm_interconnect_wrap i_interconnect (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .mem_req_i    (mem_req_i),
        .mem_rsp_o    (mem_rsp_o),
        .bank_req_o   (bank_req),
        .bank_rdata_i (bank_rdata)
    );

    // word-interleaved banks.
    for (genvar j = 0; j < `TCDM_NUM_OUT; j++) begin : gen_bank
        tcdm_bank i_bank (
            .clk_i      (clk_i),
            .bank_req_i (bank_req[j]),
            .rdata_o    (bank_rdata[j])
        );
    end

endmodule : tcdm_subsystem

`default_nettype wire

// File: tcdm_subsystem.f
+incdir+hw
hw/tcdm_pkg.sv
hw/tcdm_rr_arbiter.sv
hw/tcdm_interconnect_wrap.sv
hw/tcdm_bank.sv
hw/tcdm_subsystem.sv
bench/tcdm_subsystem_tb.sv
